// ==== hw/vec_cfg_pkg.sv ====
// Fixed sizes of the vector unit, 8 lanes of 32 bits and 8 registers
// vl_w must hold the value num_lanes itself, not just num_lanes - 1

package vec_cfg_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------

  localparam int num_lanes = 8;
  localparam int elem_w = 32;
  localparam int num_vregs = 8;

  // Register index and vector length widths
  localparam int vreg_addr_w = 3;
  localparam int vl_w = 4;

  // ----------------------------------------
  // Data types
  // ----------------------------------------

  typedef logic [elem_w-1:0] elem_t;

  // Lane 0 sits in the low 32 bits
  typedef elem_t [num_lanes-1:0] vec_t;

endpackage

// ==== hw/vec_op_pkg.sv ====
// Command opcodes of the vector unit
// Only the first eight codes run in the lanes, the rest act in the dispatcher

package vec_op_pkg;

  typedef enum logic [3:0] {
    // Element-wise arithmetic and logic
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_or    = 4'd3,
    op_xor   = 4'd4,
    // Shift by the low 5 bits of b
    op_sll   = 4'd5,
    op_srl   = 4'd6,
    // Signed compare, result is 1 or 0
    op_slt   = 4'd7,
    // vl from the scalar, clamped to the lane count
    op_setvl = 4'd8,
    // Register vs1 onto rdata
    op_read  = 4'd9
  } vec_op_t;

  // True for opcodes that go through the lane pipeline
  function automatic logic is_alu_op(input vec_op_t op);
    logic alu;
    alu = op inside {op_add, op_sub, op_and, op_or,
                     op_xor, op_sll, op_srl, op_slt};
    return alu;
  endfunction

endpackage

// ==== hw/vec_lane_if.sv ====
// Bundle between the dispatcher, one lane and the collector
// One instance per lane, no clock inside

interface vec_lane_if;

  // Issue side, dispatcher to lane
  logic                issue_valid;
  vec_op_pkg::vec_op_t op;
  vec_cfg_pkg::elem_t  a;
  vec_cfg_pkg::elem_t  b;
  logic                en;
  // Old value of the destination element
  vec_cfg_pkg::elem_t  d;

  // Result side, lane to collector
  logic                res_valid;
  logic                res_en;
  vec_cfg_pkg::elem_t  res_d;
  vec_cfg_pkg::elem_t  y;

  modport dispatch (output issue_valid, op, a, b, en, d);

  modport lane (
    input  issue_valid, op, a, b, en, d,
    output res_valid, res_en, res_d, y
  );

  modport collect (input res_valid, res_en, res_d, y);

endinterface

// ==== hw/vec_lane.sv ====
// One 32-bit lane, ALU result is registered one cycle after issue
// Shift amounts use only the low 5 bits of b

module vec_lane (
  input logic      clk,
  input logic      reset,
  vec_lane_if.lane lane
);

  vec_cfg_pkg::elem_t alu_y;

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  always_comb begin
    case (lane.op)
      vec_op_pkg::op_add: alu_y = lane.a + lane.b;
      vec_op_pkg::op_sub: alu_y = lane.a - lane.b;
      vec_op_pkg::op_and: alu_y = lane.a & lane.b;
      vec_op_pkg::op_or:  alu_y = lane.a | lane.b;
      vec_op_pkg::op_xor: alu_y = lane.a ^ lane.b;
      vec_op_pkg::op_sll: alu_y = lane.a << lane.b[4:0];
      vec_op_pkg::op_srl: alu_y = lane.a >> lane.b[4:0];
      vec_op_pkg::op_slt: begin
        alu_y = vec_cfg_pkg::elem_t'($signed(lane.a) < $signed(lane.b));
      end
      // setvl and read never reach a lane
      default: alu_y = '0;
    endcase
  end

  // ----------------------------------------
  // Result register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      lane.res_valid <= 1'b0;
    end else begin
      lane.res_valid <= lane.issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lane.issue_valid) begin
      lane.y      <= alu_y;
      lane.res_en <= lane.en;
      lane.res_d  <= lane.d;
    end
  end

endmodule

// ==== hw/vec_collect.sv ====
// Merges the lane results into one write-back word
// All lanes pulse res_valid in the same cycle

module vec_collect (
  input  logic                              clk,
  input  logic                              reset,
  vec_lane_if.collect                       lanes [vec_cfg_pkg::num_lanes],
  output logic                              wb_valid,
  output vec_cfg_pkg::vec_t                 wb_data
);

  logic [vec_cfg_pkg::num_lanes-1:0] res_valid_vec;
  logic                              lanes_done;
  vec_cfg_pkg::vec_t                 merged;

  // Disabled lanes pass the old destination element
  for (genvar i = 0; i < vec_cfg_pkg::num_lanes; i++) begin : g_merge
    assign res_valid_vec[i] = lanes[i].res_valid;
    assign merged[i]        = lanes[i].res_en ? lanes[i].y : lanes[i].res_d;
  end

  assign lanes_done = &res_valid_vec;

  // ----------------------------------------
  // Write-back register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= lanes_done;
    end
  end

  always_ff @(posedge clk) begin
    if (lanes_done) begin
      wb_data <= merged;
    end
  end

endmodule

// ==== hw/vec_dispatch.sv ====
// Accepts one command per four-phase req/ack cycle, never more in flight
// Command fields are sampled once when req is seen in idle

module vec_dispatch (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  req,
  output logic                                  ack,
  input  vec_op_pkg::vec_op_t                   op,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vd,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vs1,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vs2,
  input  vec_cfg_pkg::elem_t                    scalar,
  input  logic                                  scalar_sel,
  output vec_cfg_pkg::vec_t                     rdata,
  vec_lane_if.dispatch                          lanes [vec_cfg_pkg::num_lanes],
  input  logic                                  wb_valid,
  input  vec_cfg_pkg::vec_t                     wb_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait,
    st_ack
  } state_t;

  typedef logic [vec_cfg_pkg::vl_w-1:0] vl_t;

  state_t                                state_q;
  vl_t                                   vl_q;
  vec_cfg_pkg::vec_t                     vregs [vec_cfg_pkg::num_vregs];

  // Captured command
  vec_op_pkg::vec_op_t                   op_q;
  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vd_q;
  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vs1_q;
  logic [vec_cfg_pkg::vreg_addr_w-1:0]   vs2_q;
  vec_cfg_pkg::elem_t                    scalar_q;
  logic                                  scalar_sel_q;

  logic                                  issue_valid;

  assign ack = (state_q == st_ack);

  // ----------------------------------------
  // Command capture
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (state_q == st_idle && req) begin
      op_q         <= op;
      vd_q         <= vd;
      vs1_q        <= vs1;
      vs2_q        <= vs2;
      scalar_q     <= scalar;
      scalar_sel_q <= scalar_sel;
    end
  end

  // ----------------------------------------
  // FSM, register file, vl and readback
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q     <= st_idle;
      issue_valid <= 1'b0;
      vl_q        <= vl_t'(vec_cfg_pkg::num_lanes);
      rdata       <= '0;
      for (int r = 0; r < vec_cfg_pkg::num_vregs; r++) begin
        vregs[r] <= '0;
      end
    end else begin
      issue_valid <= 1'b0;
      case (state_q)
        st_idle: begin
          if (req) begin
            state_q <= st_issue;
          end
        end
        st_issue: begin
          if (vec_op_pkg::is_alu_op(op_q)) begin
            // One-cycle issue pulse, lanes register on the next edge
            issue_valid <= 1'b1;
            state_q     <= st_wait;
          end else begin
            // setvl and read finish here without the lanes
            state_q <= st_ack;
            if (op_q == vec_op_pkg::op_setvl) begin
              if (scalar_q > vec_cfg_pkg::elem_t'(vec_cfg_pkg::num_lanes)) begin
                vl_q <= vl_t'(vec_cfg_pkg::num_lanes);
              end else begin
                vl_q <= vl_t'(scalar_q);
              end
            end else if (op_q == vec_op_pkg::op_read) begin
              rdata <= vregs[vs1_q];
            end
          end
        end
        st_wait: begin
          if (wb_valid) begin
            vregs[vd_q] <= wb_data;
            state_q     <= st_ack;
          end
        end
        st_ack: begin
          if (!req) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Per-lane operand slices
  for (genvar i = 0; i < vec_cfg_pkg::num_lanes; i++) begin : g_issue
    assign lanes[i].issue_valid = issue_valid;
    assign lanes[i].op          = op_q;
    assign lanes[i].a           = vregs[vs1_q][i];
    assign lanes[i].b           = scalar_sel_q ? scalar_q : vregs[vs2_q][i];
    assign lanes[i].d           = vregs[vd_q][i];
    // Lanes at or above vl keep their old value
    assign lanes[i].en          = (i < int'(vl_q));
  end

endmodule

// ==== hw/vec_unit.sv ====
// Vector execution unit, 8 lanes of 32 bits with 8 vector registers
// Four-phase req/ack, command fields must stay stable while req is high
// ALU commands ack 4 cycles after req is seen, setvl and read after 1

module vec_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req,
  output logic                                ack,
  input  vec_op_pkg::vec_op_t                 op,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0] vd,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0] vs1,
  input  logic [vec_cfg_pkg::vreg_addr_w-1:0] vs2,
  input  vec_cfg_pkg::elem_t                  scalar,
  input  logic                                scalar_sel,
  output vec_cfg_pkg::vec_t                   rdata
);

  vec_lane_if lane_bus [vec_cfg_pkg::num_lanes] ();

  logic              wb_valid;
  vec_cfg_pkg::vec_t wb_data;

  vec_dispatch u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .ack        (ack),
    .op         (op),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2),
    .scalar     (scalar),
    .scalar_sel (scalar_sel),
    .rdata      (rdata),
    .lanes      (lane_bus),
    .wb_valid   (wb_valid),
    .wb_data    (wb_data)
  );

  // Identical lanes
  for (genvar i = 0; i < vec_cfg_pkg::num_lanes; i++) begin : g_lane
    vec_lane u_lane (
      .clk   (clk),
      .reset (reset),
      .lane  (lane_bus[i])
    );
  end

  vec_collect u_collect (
    .clk      (clk),
    .reset    (reset),
    .lanes    (lane_bus),
    .wb_valid (wb_valid),
    .wb_data  (wb_data)
  );

endmodule

// ==== verification/vec_checker.sv ====
// Watches the top-level ports of the vector unit, checks the req/ack protocol
// exp_rdata, exp_latency, check_rdata and test_name must be stable from req rise to ack rise

module vec_checker (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  logic              ack,
  input  vec_cfg_pkg::vec_t rdata,
  input  vec_cfg_pkg::vec_t exp_rdata,
  input  int                exp_latency,
  input  logic              check_rdata,
  input  logic [8*12-1:0]   test_name,
  output int                tests_done,
  output int                errors
);

  timeunit 1ns;
  timeprecision 1ps;

  logic ack_d;
  logic req_d;
  logic reset_d;
  // Edges since req was first seen high
  int   cycles;

  initial begin
    tests_done = 0;
    errors     = 0;
    ack_d      = 1'b0;
    req_d      = 1'b0;
    reset_d    = 1'b0;
    cycles     = 0;
  end

  // Sampled at the clock edge, before the DUT registers update
  always @(posedge clk) begin
    if (reset_d && ack !== 1'b0) begin
      $display("Error: ack is not low after reset");
      errors = errors + 1;
    end
    if (!reset) begin
      if (req === 1'b1 && req_d === 1'b0) begin
        cycles = 0;
      end else begin
        cycles = cycles + 1;
      end
      // ----------------------------------------
      // Rising ack ends a command
      // ----------------------------------------
      if (ack === 1'b1 && ack_d === 1'b0) begin
        tests_done = tests_done + 1;
        if (req_d !== 1'b1) begin
          $display("Error: ack rose while req was low in %0s", test_name);
          errors = errors + 1;
        end
        // ack rose one edge before it is seen here
        if (cycles - 1 != exp_latency) begin
          $display("Error: ack came %0d cycles after req in %0s, expected %0d",
                   cycles - 1, test_name, exp_latency);
          errors = errors + 1;
        end
        if (check_rdata && rdata !== exp_rdata) begin
          $display("Fail %0s expected %h actual %h", test_name, exp_rdata, rdata);
          errors = errors + 1;
        end else begin
          $display("Pass %0s", test_name);
        end
      end
      if (ack === 1'b0 && ack_d === 1'b1 && req_d !== 1'b0) begin
        $display("Error: ack dropped while req was still high");
        errors = errors + 1;
      end
      if (req === 1'b1 && req_d === 1'b0 && ack !== 1'b0) begin
        $display("Error: req was raised again while ack was high");
        errors = errors + 1;
      end
    end
    ack_d   = ack;
    req_d   = req;
    reset_d = reset;
  end

endmodule

// ==== verification/tb_vec_unit.sv ====
// Runs a table of commands through the vector unit under four-phase req/ack
// Expected readback comes from a shadow model of registers and vl

module tb_vec_unit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 100;
  localparam int num_rows = 23;
  localparam logic [31:0] lfsr_seed = 32'h6fdc_e660;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  typedef struct packed {
    logic [8*12-1:0]     name;
    vec_op_pkg::vec_op_t op;
    logic [2:0]          vd;
    logic [2:0]          vs1;
    logic [2:0]          vs2;
    logic                scalar_sel;
    logic                rand_scalar;
    vec_cfg_pkg::elem_t  scalar;
  } row_t;

  logic                clk;
  logic                reset;
  logic                req;
  logic                ack;
  vec_op_pkg::vec_op_t op;
  logic [2:0]          vd;
  logic [2:0]          vs1;
  logic [2:0]          vs2;
  vec_cfg_pkg::elem_t  scalar;
  logic                scalar_sel;
  vec_cfg_pkg::vec_t   rdata;

  vec_cfg_pkg::vec_t   exp_rdata;
  int                  exp_latency;
  logic                check_rdata;
  logic [8*12-1:0]     test_name;
  int                  tests_done;
  int                  errors;

  row_t                rows [num_rows];
  vec_cfg_pkg::vec_t   model [vec_cfg_pkg::num_vregs];
  int                  vl;
  logic [31:0]         lfsr;

  vec_unit u_dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .ack        (ack),
    .op         (op),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2),
    .scalar     (scalar),
    .scalar_sel (scalar_sel),
    .rdata      (rdata)
  );

  vec_checker u_check (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .ack         (ack),
    .rdata       (rdata),
    .exp_rdata   (exp_rdata),
    .exp_latency (exp_latency),
    .check_rdata (check_rdata),
    .test_name   (test_name),
    .tests_done  (tests_done),
    .errors      (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Generous bound, no row needs more than about 7 cycles
  initial begin
    #((num_rows * 10 + 20) * clk_period);
    $display("Timeout: ack never arrived, the run was stopped");
    $display("Test failures found");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic row_t make_row(input logic [8*12-1:0] name, input vec_op_pkg::vec_op_t op,
                                    input int vd, input int vs1, input int vs2,
                                    input bit sel, input bit rnd, input int scalar);
    row_t r;
    r = '{name, op, 3'(vd), 3'(vs1), 3'(vs2), sel, rnd, 32'(scalar)};
    return r;
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] next;
    next = s >> 1;
    if (s[0]) begin
      next = next ^ lfsr_taps;
    end
    return next;
  endfunction

  task automatic draw_word(output vec_cfg_pkg::elem_t w);
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Shadow model, lanes at or above vl keep their value
  task automatic apply_model(input row_t r);
    vec_cfg_pkg::vec_t  result;
    vec_cfg_pkg::elem_t a;
    vec_cfg_pkg::elem_t b;
    result = model[r.vd];
    if (vec_op_pkg::is_alu_op(r.op)) begin
      for (int i = 0; i < vec_cfg_pkg::num_lanes; i++) begin
        a = model[r.vs1][i];
        b = r.scalar_sel ? r.scalar : model[r.vs2][i];
        if (i < vl) begin
          case (r.op)
            vec_op_pkg::op_add: result[i] = a + b;
            vec_op_pkg::op_sub: result[i] = a - b;
            vec_op_pkg::op_and: result[i] = a & b;
            vec_op_pkg::op_or:  result[i] = a | b;
            vec_op_pkg::op_xor: result[i] = a ^ b;
            vec_op_pkg::op_sll: result[i] = a << b[4:0];
            vec_op_pkg::op_srl: result[i] = a >> b[4:0];
            vec_op_pkg::op_slt: result[i] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
      end
      model[r.vd] = result;
    end else if (r.op == vec_op_pkg::op_setvl) begin
      vl = (r.scalar > 32'd8) ? 8 : int'(r.scalar);
    end
  endtask

  // Called 5 ns after a rising edge, returns at the same phase
  task automatic run_command(input row_t r);
    op         = r.op;
    vd         = r.vd;
    vs1        = r.vs1;
    vs2        = r.vs2;
    scalar     = r.scalar;
    scalar_sel = r.scalar_sel;
    req        = 1'b1;
    do begin
      @(posedge clk);
      #5;
    end while (ack !== 1'b1);
    req = 1'b0;
    do begin
      @(posedge clk);
      #5;
    end while (ack !== 1'b0);
  endtask

  // ----------------------------------------
  // Stimulus table and main loop
  // ----------------------------------------

  initial begin
    row_t row;
    reset       = 1'b1;
    req         = 1'b0;
    op          = vec_op_pkg::op_add;
    vd          = '0;
    vs1         = '0;
    vs2         = '0;
    scalar      = '0;
    scalar_sel  = 1'b0;
    exp_rdata   = '0;
    exp_latency = 0;
    check_rdata = 1'b0;
    test_name   = '0;
    lfsr        = lfsr_seed;
    vl          = vec_cfg_pkg::num_lanes;
    for (int r = 0; r < vec_cfg_pkg::num_vregs; r++) begin
      model[r] = '0;
    end

    // name, op, vd, vs1, vs2, scalar_sel, random scalar, scalar
    rows[0]  = make_row("rd_reset", vec_op_pkg::op_read, 0, 3, 0, 0, 0, 0);
    rows[1]  = make_row("add_bcast", vec_op_pkg::op_add, 1, 0, 0, 1, 1, 0);
    rows[2]  = make_row("rd_bcast", vec_op_pkg::op_read, 0, 1, 0, 0, 0, 0);
    rows[3]  = make_row("setvl_3", vec_op_pkg::op_setvl, 0, 0, 0, 0, 0, 3);
    rows[4]  = make_row("add_masked", vec_op_pkg::op_add, 1, 1, 0, 1, 1, 0);
    rows[5]  = make_row("rd_masked", vec_op_pkg::op_read, 0, 1, 0, 0, 0, 0);
    rows[6]  = make_row("setvl_clamp", vec_op_pkg::op_setvl, 0, 0, 0, 0, 0, 20);
    rows[7]  = make_row("add_v2", vec_op_pkg::op_add, 2, 1, 0, 1, 1, 0);
    rows[8]  = make_row("rd_v2", vec_op_pkg::op_read, 0, 2, 0, 0, 0, 0);
    rows[9]  = make_row("sub", vec_op_pkg::op_sub, 3, 1, 2, 0, 0, 0);
    rows[10] = make_row("and", vec_op_pkg::op_and, 4, 1, 2, 0, 0, 0);
    rows[11] = make_row("or", vec_op_pkg::op_or, 5, 1, 2, 0, 0, 0);
    rows[12] = make_row("xor", vec_op_pkg::op_xor, 6, 1, 2, 0, 0, 0);
    rows[13] = make_row("sll", vec_op_pkg::op_sll, 7, 1, 2, 0, 0, 0);
    rows[14] = make_row("rd_sub", vec_op_pkg::op_read, 0, 3, 0, 0, 0, 0);
    rows[15] = make_row("rd_and", vec_op_pkg::op_read, 0, 4, 0, 0, 0, 0);
    rows[16] = make_row("rd_or", vec_op_pkg::op_read, 0, 5, 0, 0, 0, 0);
    rows[17] = make_row("rd_xor", vec_op_pkg::op_read, 0, 6, 0, 0, 0, 0);
    rows[18] = make_row("rd_sll", vec_op_pkg::op_read, 0, 7, 0, 0, 0, 0);
    rows[19] = make_row("srl", vec_op_pkg::op_srl, 3, 1, 2, 0, 0, 0);
    rows[20] = make_row("rd_srl", vec_op_pkg::op_read, 0, 3, 0, 0, 0, 0);
    rows[21] = make_row("slt", vec_op_pkg::op_slt, 4, 1, 2, 0, 0, 0);
    rows[22] = make_row("rd_slt", vec_op_pkg::op_read, 0, 4, 0, 0, 0, 0);

    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;

    for (int n = 0; n < num_rows; n++) begin
      row = rows[n];
      if (row.rand_scalar) begin
        draw_word(row.scalar);
      end
      test_name   = row.name;
      exp_rdata   = model[row.vs1];
      // Lane commands ack 4 edges after req is taken, setvl and read after 1
      exp_latency = vec_op_pkg::is_alu_op(row.op) ? 4 : 1;
      check_rdata = (row.op == vec_op_pkg::op_read);
      apply_model(row);
      run_command(row);
    end

    @(posedge clk);
    #5;
    $display("%0d of %0d tests done, %0d errors", tests_done, num_rows, errors);
    if (errors == 0 && tests_done == num_rows) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== vec_unit.f ====
hw/vec_cfg_pkg.sv
hw/vec_op_pkg.sv
hw/vec_lane_if.sv
hw/vec_lane.sv
hw/vec_collect.sv
hw/vec_dispatch.sv
hw/vec_unit.sv
verification/vec_checker.sv
verification/tb_vec_unit.sv

// ==== Bender.yml ====
package:
  name: vec_unit

sources:
  - files:
      - hw/vec_cfg_pkg.sv
      - hw/vec_op_pkg.sv
      - hw/vec_lane_if.sv
      - hw/vec_lane.sv
      - hw/vec_collect.sv
      - hw/vec_dispatch.sv
      - hw/vec_unit.sv
  - target: test
    files:
      - verification/vec_checker.sv
      - verification/tb_vec_unit.sv
